//--- list.f
+incdir+src
+incdir+test
src/line_code_pkg.sv
src/framing_pkg.sv
src/crc32_engine.sv
src/enc_8b10b.sv
src/frame_sequencer.sv
src/frame_encoder_top.sv
test/tb_frame_encoder.sv

//--- Bender.yml
package:
  name: frame_encoder

sources:
  - include_dirs:
      - src
    files:
      - src/line_code_pkg.sv
      - src/framing_pkg.sv
      - src/crc32_engine.sv
      - src/enc_8b10b.sv
      - src/frame_sequencer.sv
      - src/frame_encoder_top.sv
  - target: test
    include_dirs:
      - src
      - test
    files:
      - test/tb_frame_encoder.sv

//--- test/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Standard 5b/6b at RD-, line order abcdei with a as the MSB
localparam logic [0:31][5:0] SIX_NEG = {
	6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
	6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
	6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
	6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b at RD-, fghj, D.x.P7 in the last slot
localparam logic [0:7][3:0] FOUR_NEG = {
	4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

// K28.y 4b part following 001111
localparam logic [0:7][3:0] K28_FOUR = {
	4'b0100, 4'b1001, 4'b0101, 4'b0011, 4'b0010, 4'b1010, 4'b0110, 4'b1000
};

// Line bit a lands in bit 0
function automatic line_code_pkg::code10_t line_to_code(input logic [9:0] line);
	line_code_pkg::code10_t c;
	for (int i = 0; i < 10; i++) begin
		c[i] = line[9 - i];
	end
	return c;
endfunction

function automatic line_code_pkg::code10_t encode_symbol(input logic k,
		input line_code_pkg::byte_t b, input line_code_pkg::disp_t rd);
	logic [5:0] six;
	logic [3:0] four;
	logic rd6;
	logic alt;
	six = SIX_NEG[b[4:0]];
	four = FOUR_NEG[b[7:5]];
	if (k) begin
		if (b[4:0] == 5'd28) begin
			six = 6'b001111;
			four = K28_FOUR[b[7:5]];
		end else begin
			four = 4'b1000;
		end
		// Whole control word inverts at RD+
		if (rd) begin
			six = ~six;
			four = ~four;
		end
	end else begin
		if (rd && ($countones(six) != 3 || b[4:0] == 5'd7)) begin
			six = ~six;
		end
		rd6 = rd ^ ($countones(six) != 3);
		if (rd6) begin
			alt = (b[4:0] == 5'd11) || (b[4:0] == 5'd13) || (b[4:0] == 5'd14);
		end else begin
			alt = (b[4:0] == 5'd17) || (b[4:0] == 5'd18) || (b[4:0] == 5'd20);
		end
		if (b[7:5] == 3'd7 && alt) begin
			four = 4'b0111;
		end
		if (rd6 && ($countones(four) != 2 || b[7:5] == 3'd3 || b[7:5] == 3'd7)) begin
			four = ~four;
		end
	end
	return line_to_code({six, four});
endfunction

// MSB-first CRC-32, each byte fed LSB first
function automatic framing_pkg::crc_t crc_add_byte(input framing_pkg::crc_t c,
		input line_code_pkg::byte_t b);
	logic fb;
	for (int i = 0; i < 8; i++) begin
		fb = c[31] ^ b[i];
		c = {c[30:0], 1'b0};
		if (fb) begin
			c = c ^ 32'h04C11DB7;
		end
	end
	return c;
endfunction

// Bit reversed and complemented, as sent on the line
function automatic framing_pkg::crc_t crc_final(input framing_pkg::crc_t c);
	framing_pkg::crc_t r;
	for (int i = 0; i < 32; i++) begin
		r[i] = ~c[31 - i];
	end
	return r;
endfunction

`endif

//--- test/tb_frame_encoder.sv
`timescale 1ns/10ps

`include "link_consts.svh"

module tb_frame_encoder;
	logic clk;
	logic reset;
	logic pushin;
	logic startin;
	line_code_pkg::sym_in_t datain;
	logic pushout;
	line_code_pkg::code10_t dataout;
	logic startout;

	logic [15:0] lfsr;
	string test_name;

	// Link model with one prediction per driven cycle
	framing_pkg::seq_state_t m_state;
	line_code_pkg::disp_t m_rd;
	framing_pkg::crc_t m_crc;
	int m_left;
	framing_pkg::enc_req_t trailer_q[$];
	framing_pkg::enc_req_t exp_req;
	line_code_pkg::code10_t exp_code;

	// Control codes allowed between data bytes with K23.7 last
	localparam logic [0:11][7:0] CTRL_CODES = {
		8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC, 8'hFB, 8'hFD, 8'hFE, 8'hF7
	};

	`include "tb_frame_model.svh"

	frame_encoder_top frame_encoder_top_inst (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.pushout(pushout),
		.dataout(dataout),
		.startout(startout)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic rand_bit();
		lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		return lfsr[0];
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], rand_bit()};
		end
		return v;
	endfunction

	function automatic line_code_pkg::sym_in_t rand_sym();
		line_code_pkg::sym_in_t s;
		s.k = rand_bit();
		s.data = rand_bits(8);
		return s;
	endfunction

	function automatic logic ctrl_allowed(input line_code_pkg::byte_t b);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < 12; i++) begin
			if (CTRL_CODES[i] == b) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_code(input string what, input line_code_pkg::code10_t exp,
			input line_code_pkg::code10_t act);
		if (act !== exp) begin
			report_failure($sformatf("error %s %s expected %b actual %b",
				test_name, what, exp, act));
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			report_failure($sformatf("error %s %s expected %b actual %b",
				test_name, what, exp, act));
		end
	endtask

	task automatic check_idle();
		if (pushout !== 1'b0 || startout !== 1'b0 || dataout !== '0) begin
			report_failure($sformatf("error %s idle expected 0 0 %b actual %b %b %b",
				test_name, 10'b0, pushout, startout, dataout));
		end
	endtask

	// Request the DUT should make for these inputs
	task automatic predict(input logic p, input logic s, input line_code_pkg::sym_in_t sym);
		logic comma;
		framing_pkg::crc_t fin;
		framing_pkg::enc_req_t r;
		comma = sym.k && (sym.data == `K28_1_BYTE);
		exp_req = '0;
		exp_req.k = sym.k;
		exp_req.data = sym.data;
		case (m_state)
			framing_pkg::IDLE: begin
				if (p && s && comma) begin
					exp_req.valid = 1'b1;
					exp_req.start = 1'b1;
					m_crc = `CRC_INIT;
					m_left = `PREAMBLE_LEN - 1;
					m_state = framing_pkg::PREAMBLE;
				end
			end
			framing_pkg::PREAMBLE: begin
				if (p && comma) begin
					exp_req.valid = 1'b1;
					m_left = m_left - 1;
					if (m_left == 0) begin
						m_state = framing_pkg::DATA;
					end
				end else if (p) begin
					m_state = framing_pkg::IDLE;
				end
			end
			framing_pkg::DATA: begin
				if (p && !sym.k) begin
					exp_req.valid = 1'b1;
					m_crc = crc_add_byte(m_crc, sym.data);
				end else if (p && ctrl_allowed(sym.data)) begin
					exp_req.valid = 1'b1;
				end
				if (exp_req.valid && sym.k && sym.data == `K23_7_BYTE) begin
					fin = crc_final(m_crc);
					for (int i = 0; i < `CRC_BYTES; i++) begin
						r = '0;
						r.valid = 1'b1;
						r.data = fin[8 * i +: 8];
						trailer_q.push_back(r);
					end
					r.k = 1'b1;
					r.data = `K28_5_BYTE;
					trailer_q.push_back(r);
					// Guard cycle after K28.5
					r = '0;
					trailer_q.push_back(r);
					m_state = framing_pkg::CRC_OUT;
				end
			end
			framing_pkg::CRC_OUT: begin
				exp_req = trailer_q.pop_front();
				if (trailer_q.size() == 0) begin
					m_state = framing_pkg::IDLE;
				end
			end
		endcase
		if (exp_req.valid) begin
			exp_code = encode_symbol(exp_req.k, exp_req.data, m_rd);
			m_rd = m_rd ^ ($countones(exp_code) != 5);
		end
	endtask

	// Check the last prediction and drive the next inputs
	task automatic step(input logic p, input logic s, input line_code_pkg::sym_in_t sym);
		@(posedge clk);
		#1;
		check_flag("pushout", exp_req.valid, pushout);
		check_flag("startout", exp_req.valid && exp_req.start, startout);
		if (exp_req.valid) begin
			check_code("dataout", exp_code, dataout);
		end
		pushin = p;
		startin = s;
		datain = sym;
		predict(p, s, sym);
	endtask

	// Roughly one gap in four with junk on the bus
	task automatic insert_gap();
		int n;
		logic s;
		line_code_pkg::sym_in_t sym;
		n = 0;
		if (rand_bits(2) == 8'd0) begin
			n = 1 + rand_bits(2);
		end
		for (int i = 0; i < n; i++) begin
			s = rand_bit();
			sym = rand_sym();
			step(1'b0, s, sym);
		end
	endtask

	task automatic abort_preamble();
		int n;
		line_code_pkg::byte_t b;
		test_name = "abort";
		n = rand_bits(2) % 3;
		step(1'b1, 1'b1, {1'b1, `K28_1_BYTE});
		for (int i = 0; i < n; i++) begin
			step(1'b1, 1'b0, {1'b1, `K28_1_BYTE});
		end
		b = rand_bits(8);
		step(1'b1, 1'b0, {1'b0, b});
	endtask

	task automatic send_frame();
		int len;
		int idx;
		logic [7:0] pick;
		logic s;
		line_code_pkg::sym_in_t sym;
		test_name = "preamble";
		step(1'b1, 1'b1, {1'b1, `K28_1_BYTE});
		for (int i = 1; i < `PREAMBLE_LEN; i++) begin
			insert_gap();
			step(1'b1, 1'b0, {1'b1, `K28_1_BYTE});
		end
		test_name = "data";
		len = 1 + rand_bits(4);
		for (int i = 0; i < len; i++) begin
			insert_gap();
			pick = rand_bits(4);
			s = rand_bit();
			if (pick == 8'd0) begin
				idx = rand_bits(4) % 11;
				sym = {1'b1, CTRL_CODES[idx]};
			end else if (pick == 8'd1) begin
				sym = rand_sym();
				sym.k = 1'b1;
				if (ctrl_allowed(sym.data)) begin
					sym.data = 8'h00;
				end
			end else begin
				sym = rand_sym();
				sym.k = 1'b0;
			end
			step(1'b1, s, sym);
		end
		test_name = "trailer";
		step(1'b1, 1'b0, {1'b1, `K23_7_BYTE});
		// CRC bytes, K28.5 and one guard cycle
		for (int i = 0; i < `CRC_BYTES + 2; i++) begin
			// Starts and symbols here must be ignored
			if (rand_bit()) begin
				sym = {1'b1, `K28_1_BYTE};
			end else begin
				sym = rand_sym();
			end
			step(1'b1, 1'b1, sym);
		end
	endtask

	initial begin
		lfsr = 16'd4923;
		reset = 1'b1;
		pushin = 1'b0;
		startin = 1'b0;
		datain = '0;
		m_state = framing_pkg::IDLE;
		m_rd = 1'b0;
		m_crc = `CRC_INIT;
		m_left = 0;
		exp_req = '0;
		exp_code = '0;
		test_name = "reset";
		repeat (8) begin
			@(posedge clk);
		end
		#1;
		reset = 1'b0;
		check_idle();

		// A frame needs pushin, startin and K28.1 together
		test_name = "no_start";
		step(1'b1, 1'b1, {1'b1, `K28_5_BYTE});
		step(1'b0, 1'b1, {1'b1, `K28_1_BYTE});
		step(1'b1, 1'b0, {1'b1, `K28_1_BYTE});
		step(1'b1, 1'b1, {1'b0, `K28_1_BYTE});
		step(1'b0, 1'b0, '0);
		check_idle();

		for (int f = 0; f < 24; f++) begin
			if (rand_bits(2) == 8'd0) begin
				abort_preamble();
			end
			send_frame();
			insert_gap();
		end
		test_name = "drain";
		repeat (3) begin
			step(1'b0, 1'b0, '0);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- src/frame_encoder_top.sv
`timescale 1ns/10ps

module frame_encoder_top (
	input  logic clk,
	input  logic reset,
	input  logic pushin,
	input  logic startin,
	input  line_code_pkg::sym_in_t datain,
	output logic pushout,
	output line_code_pkg::code10_t dataout,
	output logic startout
);
	framing_pkg::enc_req_t req;
	logic crc_clear;
	logic crc_update;
	line_code_pkg::byte_t crc_byte;
	framing_pkg::crc_t crc_value;

	frame_sequencer frame_sequencer_inst (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.req(req),
		.crc_clear(crc_clear),
		.crc_update(crc_update),
		.crc_byte(crc_byte),
		.crc_value(crc_value)
	);

	// Trailer CRC over data bytes only
	crc32_engine crc32_engine_inst (
		.clk(clk),
		.reset(reset),
		.crc_clear(crc_clear),
		.crc_update(crc_update),
		.crc_byte(crc_byte),
		.crc_value(crc_value)
	);

	enc_8b10b enc_8b10b_inst (
		.clk(clk),
		.reset(reset),
		.req(req),
		.pushout(pushout),
		.startout(startout),
		.dataout(dataout)
	);

endmodule

//--- src/frame_sequencer.sv
`timescale 1ns/10ps

`include "link_consts.svh"

module frame_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic pushin,
	input  logic startin,
	input  line_code_pkg::sym_in_t datain,
	output framing_pkg::enc_req_t req,
	output logic crc_clear,
	output logic crc_update,
	output line_code_pkg::byte_t crc_byte,
	input  framing_pkg::crc_t crc_value
);
	framing_pkg::seq_state_t state;
	framing_pkg::seq_state_t state_next;
	framing_pkg::seq_cnt_t cnt;
	framing_pkg::seq_cnt_t cnt_next;
	logic is_comma;
	logic is_eod;
	logic is_ctrl_ok;

	assign is_comma = datain.k && (datain.data == `K28_1_BYTE);
	assign is_eod = datain.k && (datain.data == `K23_7_BYTE);

	// Control codes that may appear between data bytes
	assign is_ctrl_ok = datain.k && ((datain.data[4:0] == `K28_LOW_BITS) ||
		(datain.data == `K23_7_BYTE) || (datain.data == `K27_7_BYTE) ||
		(datain.data == `K29_7_BYTE) || (datain.data == `K30_7_BYTE));

	assign crc_byte = datain.data;

	always_comb begin
		state_next = state;
		cnt_next = cnt;
		req = '0;
		req.k = datain.k;
		req.data = datain.data;
		crc_clear = 1'b0;
		crc_update = 1'b0;
		case (state)
			framing_pkg::IDLE: begin
				if (pushin && startin && is_comma) begin
					req.valid = 1'b1;
					req.start = 1'b1;
					crc_clear = 1'b1;
					cnt_next = framing_pkg::seq_cnt_t'(`PREAMBLE_LEN - 1);
					state_next = framing_pkg::PREAMBLE;
				end
			end
			framing_pkg::PREAMBLE: begin
				if (pushin) begin
					if (is_comma) begin
						req.valid = 1'b1;
						cnt_next = cnt - 1'b1;
						if (cnt == 3'd1) begin
							state_next = framing_pkg::DATA;
						end
					end else begin
						state_next = framing_pkg::IDLE;
					end
				end
			end
			framing_pkg::DATA: begin
				if (pushin && !datain.k) begin
					req.valid = 1'b1;
					crc_update = 1'b1;
				end else if (pushin && is_ctrl_ok) begin
					req.valid = 1'b1;
					if (is_eod) begin
						cnt_next = '0;
						state_next = framing_pkg::CRC_OUT;
					end
				end
			end
			framing_pkg::CRC_OUT: begin
				req.valid = 1'b1;
				req.k = 1'b0;
				req.data = crc_value[8 * cnt +: 8];
				if (cnt == framing_pkg::seq_cnt_t'(`CRC_BYTES - 1)) begin
					cnt_next = '0;
					state_next = framing_pkg::CLOSE;
				end else begin
					cnt_next = cnt + 1'b1;
				end
			end
			framing_pkg::CLOSE: begin
				// K28.5 first, then one guard cycle while it leaves
				if (cnt == '0) begin
					req.valid = 1'b1;
					req.k = 1'b1;
					req.data = `K28_5_BYTE;
					cnt_next = 3'd1;
				end else begin
					state_next = framing_pkg::IDLE;
				end
			end
			default: begin
				state_next = framing_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= framing_pkg::IDLE;
			cnt <= '0;
		end else begin
			state <= state_next;
			cnt <= cnt_next;
		end
	end

endmodule

//--- src/enc_8b10b.sv
`timescale 1ns/10ps

`include "link_consts.svh"

module enc_8b10b (
	input  logic clk,
	input  logic reset,
	input  framing_pkg::enc_req_t req,
	output logic pushout,
	output logic startout,
	output line_code_pkg::code10_t dataout
);
	line_code_pkg::disp_t rd;
	line_code_pkg::disp_t rd_mid;
	line_code_pkg::disp_t rd_next;
	line_code_pkg::code6_t neg6;
	line_code_pkg::code6_t code6;
	line_code_pkg::code4_t neg4;
	line_code_pkg::code4_t code4;
	line_code_pkg::code4_t k28_4;
	line_code_pkg::code10_t k_neg;
	line_code_pkg::code10_t k_word;
	line_code_pkg::code10_t word;
	logic [4:0] x;
	logic [2:0] y;
	logic use_a7;

	assign x = req.data[4:0];
	assign y = req.data[7:5];

	// 5b/6b for negative disparity, written with bit 0 as line bit a
	always_comb begin
		case (x)
			5'd0: neg6 = 6'b111001;
			5'd1: neg6 = 6'b101110;
			5'd2: neg6 = 6'b101101;
			5'd3: neg6 = 6'b100011;
			5'd4: neg6 = 6'b101011;
			5'd5: neg6 = 6'b100101;
			5'd6: neg6 = 6'b100110;
			5'd7: neg6 = 6'b000111;
			5'd8: neg6 = 6'b100111;
			5'd9: neg6 = 6'b101001;
			5'd10: neg6 = 6'b101010;
			5'd11: neg6 = 6'b001011;
			5'd12: neg6 = 6'b101100;
			5'd13: neg6 = 6'b001101;
			5'd14: neg6 = 6'b001110;
			5'd15: neg6 = 6'b111010;
			5'd16: neg6 = 6'b110110;
			5'd17: neg6 = 6'b110001;
			5'd18: neg6 = 6'b110010;
			5'd19: neg6 = 6'b010011;
			5'd20: neg6 = 6'b110100;
			5'd21: neg6 = 6'b010101;
			5'd22: neg6 = 6'b010110;
			5'd23: neg6 = 6'b010111;
			5'd24: neg6 = 6'b110011;
			5'd25: neg6 = 6'b011001;
			5'd26: neg6 = 6'b011010;
			5'd27: neg6 = 6'b011011;
			5'd28: neg6 = 6'b011100;
			5'd29: neg6 = 6'b011101;
			5'd30: neg6 = 6'b011110;
			default: neg6 = 6'b110101;
		endcase
	end

	// Unbalanced codes and D.7 flip for positive disparity
	assign code6 = (rd && (($countones(neg6) != 3) || (x == 5'd7))) ? ~neg6 : neg6;
	assign rd_mid = rd ^ ($countones(code6) != 3);

	// Alternate D.x.7 avoids a run of five
	always_comb begin
		if (rd_mid == 1'b0) begin
			use_a7 = (x == 5'd17) || (x == 5'd18) || (x == 5'd20);
		end else begin
			use_a7 = (x == 5'd11) || (x == 5'd13) || (x == 5'd14);
		end
	end

	// 3b/4b for negative disparity after the 6b subblock
	always_comb begin
		case (y)
			3'd0: neg4 = 4'b1101;
			3'd1: neg4 = 4'b1001;
			3'd2: neg4 = 4'b1010;
			3'd3: neg4 = 4'b0011;
			3'd4: neg4 = 4'b1011;
			3'd5: neg4 = 4'b0101;
			3'd6: neg4 = 4'b0110;
			default: neg4 = use_a7 ? 4'b1110 : 4'b0111;
		endcase
	end

	assign code4 = (rd_mid && (($countones(neg4) != 2) || (y == 3'd3) || (y == 3'd7))) ?
		~neg4 : neg4;

	// K28.y 4b subblock following the negative 6b form
	always_comb begin
		case (y)
			3'd0: k28_4 = 4'b0010;
			3'd1: k28_4 = 4'b1001;
			3'd2: k28_4 = 4'b1010;
			3'd3: k28_4 = 4'b1100;
			3'd4: k28_4 = 4'b0100;
			3'd5: k28_4 = 4'b0101;
			3'd6: k28_4 = 4'b0110;
			default: k28_4 = 4'b0001;
		endcase
	end

	// Other control codes are K.x.7 with the data 6b subblock
	assign k_neg = (x == `K28_LOW_BITS) ? {k28_4, 6'b111100} : {4'b0001, neg6};

	// Positive form of every control code is the complement
	assign k_word = rd ? ~k_neg : k_neg;

	assign word = req.k ? k_word : {code4, code6};
	assign rd_next = rd ^ ($countones(word) != 5);

	always_ff @(posedge clk) begin
		if (reset) begin
			rd <= 1'b0;
			pushout <= 1'b0;
			startout <= 1'b0;
			dataout <= '0;
		end else begin
			pushout <= req.valid;
			startout <= req.valid && req.start;
			if (req.valid) begin
				dataout <= word;
				rd <= rd_next;
			end
		end
	end

endmodule

//--- src/crc32_engine.sv
`timescale 1ns/10ps

`include "link_consts.svh"

module crc32_engine (
	input  logic clk,
	input  logic reset,
	input  logic crc_clear,
	input  logic crc_update,
	input  line_code_pkg::byte_t crc_byte,
	output framing_pkg::crc_t crc_value
);
	framing_pkg::crc_t crc_reg;
	framing_pkg::crc_t crc_next;

	// Reflected CRC, one bit per step with the LSB first
	always_comb begin
		crc_next = crc_reg ^ {24'd0, crc_byte};
		for (int i = 0; i < 8; i++) begin
			if (crc_next[0]) begin
				crc_next = (crc_next >> 1) ^ `CRC_POLY;
			end else begin
				crc_next = crc_next >> 1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			crc_reg <= `CRC_INIT;
		end else if (crc_clear) begin
			crc_reg <= `CRC_INIT;
		end else if (crc_update) begin
			crc_reg <= crc_next;
		end
	end

	// Ethernet convention
	assign crc_value = ~crc_reg;

endmodule

//--- src/framing_pkg.sv
package framing_pkg;

	// Frame sequencer states
	typedef enum logic [2:0] {
		IDLE,
		PREAMBLE,
		DATA,
		CRC_OUT,
		CLOSE
	} seq_state_t;

	// One symbol request to the encoder
	typedef struct packed {
		logic valid;
		logic start;
		logic k;
		line_code_pkg::byte_t data;
	} enc_req_t;

	// CRC-32 register and result
	typedef logic [31:0] crc_t;

	// Preamble countdown and trailer byte index
	typedef logic [2:0] seq_cnt_t;

endpackage

//--- src/line_code_pkg.sv
package line_code_pkg;

	// One data or control byte
	typedef logic [7:0] byte_t;

	// Input symbol with its control flag
	typedef struct packed {
		logic k;
		byte_t data;
	} sym_in_t;

	// Line bit a sits in bit 0 and line bit j in bit 9
	typedef logic [9:0] code10_t;

	// 6b subblock, bits 5:0 of a code word
	typedef logic [5:0] code6_t;

	// 4b subblock, bits 9:6 of a code word
	typedef logic [3:0] code4_t;

	// 0 means negative running disparity
	typedef logic disp_t;

endpackage

//--- src/link_consts.svh
`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// Preamble comma
`define K28_1_BYTE 8'h3C

// End of the data phase
`define K23_7_BYTE 8'hF7

// Frame close
`define K28_5_BYTE 8'hBC

// Other K.x.7 codes allowed in the data phase
`define K27_7_BYTE 8'hFB
`define K29_7_BYTE 8'hFD
`define K30_7_BYTE 8'hFE

// Low five bits shared by all K28.y codes
`define K28_LOW_BITS 5'd28

// Comma symbols per preamble
`define PREAMBLE_LEN 4

// Reflected IEEE 802.3 polynomial
`define CRC_POLY 32'hEDB88320
`define CRC_INIT 32'hFFFFFFFF

// Trailer bytes, least significant first
`define CRC_BYTES 4

`endif
